/* source/tia_pkg.sv */
`default_nettype none

package tia_pkg;

  localparam int DATA_W  = 8;                 // CPU data bus
  localparam int ADDR_W  = 6;                 // TIA register space
  localparam int COLOR_W = 7;                 // Hue and luminance

  typedef logic [COLOR_W-1:0] color_t;

  // Write-only registers
  localparam logic [ADDR_W-1:0] A_VSYNC  = 6'h00;
  localparam logic [ADDR_W-1:0] A_VBLANK = 6'h01;
  localparam logic [ADDR_W-1:0] A_WSYNC  = 6'h02;
  localparam logic [ADDR_W-1:0] A_COLUP0 = 6'h06;
  localparam logic [ADDR_W-1:0] A_COLUPF = 6'h08;
  localparam logic [ADDR_W-1:0] A_COLUBK = 6'h09;
  localparam logic [ADDR_W-1:0] A_CTRLPF = 6'h0A;
  localparam logic [ADDR_W-1:0] A_REFP0  = 6'h0B;
  localparam logic [ADDR_W-1:0] A_PF0    = 6'h0D;
  localparam logic [ADDR_W-1:0] A_PF1    = 6'h0E;
  localparam logic [ADDR_W-1:0] A_PF2    = 6'h0F;
  localparam logic [ADDR_W-1:0] A_RESP0  = 6'h10;
  localparam logic [ADDR_W-1:0] A_RESBL  = 6'h14;
  localparam logic [ADDR_W-1:0] A_GRP0   = 6'h1B;
  localparam logic [ADDR_W-1:0] A_GRP1   = 6'h1C;   // Only latches the delayed P0 copy
  localparam logic [ADDR_W-1:0] A_ENABL  = 6'h1F;
  localparam logic [ADDR_W-1:0] A_VDELP0 = 6'h25;
  localparam logic [ADDR_W-1:0] A_CXCLR  = 6'h2C;

  // Read registers, decoded on the low nibble
  localparam logic [3:0] R_CXP0FB = 4'h2;
  localparam logic [3:0] R_CXBLPF = 4'h6;
  localparam logic [3:0] R_INPT4  = 4'hC;

  // NTSC raster
  localparam int LINE_CLKS    = 228;
  localparam int FRAME_LINES  = 262;
  localparam int VISIBLE_W    = 160;
  localparam int FIRST_LINE   = 22;         // First line stored in the frame buffer
  localparam int PICTURE_LINE = 38;         // Lines above this are forced black

  localparam int RES_DELAY = 5;             // Object start lags the RESxx strobe
  localparam int PF_BITS   = 20;

  // Collision word, bit 0 P0-PF, bit 1 P0-BL, bit 2 BL-PF
  localparam int CX_W = 3;

  localparam int XPOS_W  = 8;
  localparam int YPOS_W  = 9;
  localparam int VADDR_W = 16;

endpackage

`default_nettype wire

/* source/tia_regs_if.sv */
`default_nettype none

interface tia_regs_if;
  import tia_pkg::*;

  color_t colup0;
  color_t colupf;
  color_t colubk;

  logic [PF_BITS-1:0] pf;                   // PF0, PF1, PF2 in scan order
  logic               refpf;
  logic               scorepf;
  logic               pf_priority;

  logic [3:0]         ball_w;               // 1, 2, 4 or 8 pixels
  logic               enabl;
  logic [XPOS_W-1:0]  x_bl;

  logic [DATA_W-1:0]  grp0;
  logic [DATA_W-1:0]  old_grp0;
  logic               refp0;
  logic               vdelp0;
  logic [XPOS_W-1:0]  x_p0;

  logic               cx_clr;               // One-clock clear pulse

  modport regs_mp (
    output colup0, colupf, colubk, pf, refpf, scorepf, pf_priority,
           ball_w, enabl, x_bl, grp0, old_grp0, refp0, vdelp0, x_p0, cx_clr
  );

  modport render_mp (
    input pf, refpf, ball_w, enabl, x_bl, grp0, old_grp0, refp0, vdelp0, x_p0, cx_clr
  );

  modport color_mp (
    input colup0, colupf, colubk, scorepf, pf_priority
  );

endinterface

`default_nettype wire

/* source/tia_regs.sv */
`default_nettype none

module tia_regs (
  input  logic                        clk,
  input  logic                        reset,
  input  logic                        cpu_enable_i,
  input  logic                        stb_i,
  input  logic                        we_i,
  input  logic [tia_pkg::ADDR_W-1:0]  adr_i,
  input  logic [tia_pkg::DATA_W-1:0]  dat_i,
  input  logic                        fire_i,
  input  logic [tia_pkg::XPOS_W-1:0]  xpos_i,
  input  logic [tia_pkg::CX_W-1:0]    cx_i,
  output logic [tia_pkg::DATA_W-1:0]  dat_o_o,
  output logic                        stall_cpu_o,
  output logic                        vsync_o,
  output logic                        vblank_o,
  output logic                        vsync_start_o,
  tia_regs_if.regs_mp                 regs
);
  import tia_pkg::*;

  logic              wr_en;
  logic              rd_en;
  logic [XPOS_W-1:0] res_pos;

  // PF1 is shifted out LSB last, so its bits land reversed
  function automatic logic [DATA_W-1:0] bit_rev(input logic [DATA_W-1:0] d);
    logic [DATA_W-1:0] r;
    for (int i = 0; i < DATA_W; i++) begin
      r[i] = d[DATA_W-1-i];
    end
    return r;
  endfunction

  assign wr_en = stb_i && we_i && cpu_enable_i;
  assign rd_en = stb_i && !we_i;

  // Rising edge of VSYNC restarts the beam
  assign vsync_start_o = wr_en && (adr_i == A_VSYNC) && dat_i[1] && !vsync_o;

  // Strobes during horizontal blank park the object at the left edge
  assign res_pos = (xpos_i >= XPOS_W'(VISIBLE_W)) ? '0 : xpos_i + XPOS_W'(RES_DELAY);

  always_ff @(posedge clk) begin
    if (reset) begin
      regs.colup0      <= '0;
      regs.colupf      <= '0;
      regs.colubk      <= '0;
      regs.pf          <= '0;
      regs.refpf       <= 1'b0;
      regs.scorepf     <= 1'b0;
      regs.pf_priority <= 1'b0;
      regs.ball_w      <= '0;
      regs.enabl       <= 1'b0;
      regs.x_bl        <= '0;
      regs.grp0        <= '0;
      regs.old_grp0    <= '0;
      regs.refp0       <= 1'b0;
      regs.vdelp0      <= 1'b0;
      regs.x_p0        <= '0;
      regs.cx_clr      <= 1'b0;
      vsync_o          <= 1'b0;
      vblank_o         <= 1'b0;
    end else begin
      regs.cx_clr <= 1'b0;
      if (wr_en) begin
        case (adr_i)
          A_VSYNC:  vsync_o <= dat_i[1];
          A_VBLANK: vblank_o <= dat_i[1];
          A_COLUP0: regs.colup0 <= dat_i[DATA_W-1:1];     // Bit 0 unused
          A_COLUPF: regs.colupf <= dat_i[DATA_W-1:1];
          A_COLUBK: regs.colubk <= dat_i[DATA_W-1:1];
          A_CTRLPF: begin
            regs.refpf       <= dat_i[0];
            regs.scorepf     <= dat_i[1];
            regs.pf_priority <= dat_i[2];
            regs.ball_w      <= 4'b0001 << dat_i[5:4];
          end
          A_REFP0:  regs.refp0 <= dat_i[3];
          A_PF0:    regs.pf[3:0] <= dat_i[7:4];            // Upper nibble only
          A_PF1:    regs.pf[11:4] <= bit_rev(dat_i);
          A_PF2:    regs.pf[19:12] <= dat_i;
          A_RESP0:  regs.x_p0 <= res_pos;
          A_RESBL:  regs.x_bl <= res_pos;
          A_GRP0:   regs.grp0 <= dat_i;
          A_GRP1:   regs.old_grp0 <= regs.grp0;            // Delayed copy for VDELP0
          A_ENABL:  regs.enabl <= dat_i[1];
          A_VDELP0: regs.vdelp0 <= dat_i[0];
          A_CXCLR:  regs.cx_clr <= 1'b1;
          default:  ;
        endcase
      end
    end
  end

  // WSYNC halts the CPU until the end of the visible line
  always_ff @(posedge clk) begin
    if (reset) begin
      stall_cpu_o <= 1'b0;
    end else if (wr_en && (adr_i == A_WSYNC)) begin
      stall_cpu_o <= 1'b1;
    end else if (xpos_i == XPOS_W'(VISIBLE_W)) begin
      stall_cpu_o <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      dat_o_o <= '0;
    end else if (rd_en) begin
      case (adr_i[3:0])
        R_CXP0FB: dat_o_o <= {cx_i[0], cx_i[1], 6'b0};   // P0-PF, P0-BL
        R_CXBLPF: dat_o_o <= {cx_i[2], 7'b0};
        R_INPT4:  dat_o_o <= {fire_i, 7'b0};
        default:  dat_o_o <= '0;
      endcase
    end
  end

endmodule

`default_nettype wire

/* source/beam_counter.sv */
`default_nettype none

module beam_counter (
  input  logic                        clk,
  input  logic                        reset,
  input  logic                        enable_i,
  input  logic                        vsync_start_i,
  output logic [tia_pkg::XPOS_W-1:0]  xpos_o,
  output logic [tia_pkg::YPOS_W-1:0]  ypos_o,
  output logic                        in_frame_o
);
  import tia_pkg::*;

  logic line_end;

  assign line_end = (xpos_o == XPOS_W'(LINE_CLKS - 1));

  // Line past the last one is a one-tick pause before the raster wraps
  assign in_frame_o = (ypos_o < YPOS_W'(FRAME_LINES));

  always_ff @(posedge clk) begin
    if (reset) begin
      xpos_o <= '0;
      ypos_o <= '0;
    end else if (vsync_start_i) begin
      xpos_o <= '0;                         // Restart at the origin
      ypos_o <= '0;
    end else if (enable_i) begin
      if (in_frame_o) begin
        if (line_end) begin
          xpos_o <= '0;
          ypos_o <= ypos_o + 1'b1;
        end else begin
          xpos_o <= xpos_o + 1'b1;
        end
      end else begin
        ypos_o <= '0;                       // x is already zero here
      end
    end
  end

endmodule

`default_nettype wire

/* source/object_render.sv */
`default_nettype none

module object_render (
  input  logic                        clk,
  input  logic                        reset,
  input  logic                        enable_i,
  input  logic [tia_pkg::XPOS_W-1:0]  xpos_i,
  input  logic                        in_frame_i,
  output logic                        pf_bit_o,
  output logic                        bl_bit_o,
  output logic                        p0_bit_o,
  output logic [tia_pkg::CX_W-1:0]    cx_o,
  tia_regs_if.render_mp               regs
);
  import tia_pkg::*;

  logic                        visible;
  logic [XPOS_W-1:0]           pf_col;
  logic [$clog2(PF_BITS)-1:0]  pf_idx;
  logic [XPOS_W:0]             bl_end;
  logic [XPOS_W-1:0]           p0_off;
  logic [2:0]                  p0_col;
  logic [DATA_W-1:0]           p0_gfx;

  assign visible = (xpos_i < XPOS_W'(VISIBLE_W));

  // Right half either repeats the left half or mirrors it
  always_comb begin
    if (xpos_i < XPOS_W'(VISIBLE_W / 2)) begin
      pf_col = xpos_i;
    end else if (regs.refpf) begin
      pf_col = XPOS_W'(VISIBLE_W - 1) - xpos_i;
    end else begin
      pf_col = xpos_i - XPOS_W'(VISIBLE_W / 2);
    end
  end

  assign pf_idx   = pf_col[$clog2(PF_BITS)+1:2];   // Four pixels per PF bit
  assign pf_bit_o = visible && regs.pf[pf_idx];

  assign bl_end   = {1'b0, regs.x_bl} + (XPOS_W + 1)'(regs.ball_w);
  assign bl_bit_o = visible && regs.enabl && (xpos_i >= regs.x_bl) &&
                    ({1'b0, xpos_i} < bl_end);

  // Player graphics go out MSB first, LSB first when reflected
  assign p0_off   = xpos_i - regs.x_p0;
  assign p0_col   = regs.refp0 ? p0_off[2:0] : ~p0_off[2:0];
  assign p0_gfx   = regs.vdelp0 ? regs.old_grp0 : regs.grp0;
  assign p0_bit_o = visible && (xpos_i >= regs.x_p0) &&
                    (p0_off < XPOS_W'(DATA_W)) && p0_gfx[p0_col];

  always_ff @(posedge clk) begin
    if (reset) begin
      cx_o <= '0;
    end else if (regs.cx_clr) begin
      cx_o <= '0;
    end else if (enable_i && in_frame_i) begin
      cx_o <= cx_o | {bl_bit_o && pf_bit_o,
                      p0_bit_o && bl_bit_o,
                      p0_bit_o && pf_bit_o};
    end
  end

endmodule

`default_nettype wire

/* source/pixel_out.sv */
`default_nettype none

module pixel_out (
  input  logic                         clk,
  input  logic                         reset,
  input  logic                         enable_i,
  input  logic [tia_pkg::XPOS_W-1:0]   xpos_i,
  input  logic [tia_pkg::YPOS_W-1:0]   ypos_i,
  input  logic                         in_frame_i,
  input  logic                         pf_bit_i,
  input  logic                         bl_bit_i,
  input  logic                         p0_bit_i,
  output tia_pkg::color_t              vid_out_o,
  output logic [tia_pkg::VADDR_W-1:0]  vid_addr_o,
  output logic                         vid_wr_o,
  tia_regs_if.color_mp                 regs
);
  import tia_pkg::*;

  color_t             pf_color;
  color_t             pix_color;
  logic               draw;
  logic [VADDR_W-1:0] pix_addr;

  assign pf_color = regs.scorepf ? regs.colup0 : regs.colupf;   // Score mode uses P0 color

  always_comb begin
    if (ypos_i < YPOS_W'(PICTURE_LINE)) begin
      pix_color = '0;
    end else if (bl_bit_i) begin
      pix_color = regs.colupf;
    end else if (regs.pf_priority && pf_bit_i) begin
      pix_color = pf_color;                 // Playfield in front of player
    end else if (p0_bit_i) begin
      pix_color = regs.colup0;
    end else if (pf_bit_i) begin
      pix_color = pf_color;
    end else begin
      pix_color = regs.colubk;
    end
  end

  assign draw = enable_i && in_frame_i && (ypos_i >= YPOS_W'(FIRST_LINE)) &&
                (xpos_i < XPOS_W'(VISIBLE_W));

  assign pix_addr = VADDR_W'(ypos_i - YPOS_W'(FIRST_LINE)) * VADDR_W'(VISIBLE_W) +
                    VADDR_W'(xpos_i);

  always_ff @(posedge clk) begin
    if (reset) begin
      vid_out_o  <= '0;
      vid_addr_o <= '0;
      vid_wr_o   <= 1'b0;
    end else begin
      vid_wr_o <= draw;
      if (draw) begin
        vid_out_o  <= pix_color;
        vid_addr_o <= pix_addr;
      end
    end
  end

endmodule

`default_nettype wire

/* source/tia_top.sv */
`default_nettype none

module tia_top (
  input  logic                         clk,
  input  logic                         reset,
  input  logic                         enable_i,
  input  logic                         cpu_enable_i,
  input  logic                         stb_i,
  input  logic                         we_i,
  input  logic [tia_pkg::ADDR_W-1:0]   adr_i,
  input  logic [tia_pkg::DATA_W-1:0]   dat_i,
  input  logic                         fire_i,
  output logic [tia_pkg::DATA_W-1:0]   dat_o,
  output logic                         stall_cpu_o,
  output tia_pkg::color_t              vid_out_o,
  output logic                         vid_vsync_o,
  output logic                         vid_vblank_o,
  output logic [tia_pkg::VADDR_W-1:0]  vid_addr_o,
  output logic                         vid_wr_o
);
  import tia_pkg::*;

  logic [XPOS_W-1:0] xpos;
  logic [YPOS_W-1:0] ypos;
  logic              in_frame;
  logic              vsync_start;
  logic              pf_bit;
  logic              bl_bit;
  logic              p0_bit;
  logic [CX_W-1:0]   cx;

  tia_regs_if regs_bus ();                  // Register state to the renderer

  tia_regs u_regs (
    .clk           (clk),
    .reset         (reset),
    .cpu_enable_i  (cpu_enable_i),
    .stb_i         (stb_i),
    .we_i          (we_i),
    .adr_i         (adr_i),
    .dat_i         (dat_i),
    .fire_i        (fire_i),
    .xpos_i        (xpos),
    .cx_i          (cx),
    .dat_o_o       (dat_o),
    .stall_cpu_o   (stall_cpu_o),
    .vsync_o       (vid_vsync_o),
    .vblank_o      (vid_vblank_o),
    .vsync_start_o (vsync_start),
    .regs          (regs_bus)
  );

  beam_counter u_beam (
    .clk           (clk),
    .reset         (reset),
    .enable_i      (enable_i),
    .vsync_start_i (vsync_start),
    .xpos_o        (xpos),
    .ypos_o        (ypos),
    .in_frame_o    (in_frame)
  );

  object_render u_render (
    .clk        (clk),
    .reset      (reset),
    .enable_i   (enable_i),
    .xpos_i     (xpos),
    .in_frame_i (in_frame),
    .pf_bit_o   (pf_bit),
    .bl_bit_o   (bl_bit),
    .p0_bit_o   (p0_bit),
    .cx_o       (cx),
    .regs       (regs_bus)
  );

  pixel_out u_pixel (
    .clk        (clk),
    .reset      (reset),
    .enable_i   (enable_i),
    .xpos_i     (xpos),
    .ypos_i     (ypos),
    .in_frame_i (in_frame),
    .pf_bit_i   (pf_bit),
    .bl_bit_i   (bl_bit),
    .p0_bit_i   (p0_bit),
    .vid_out_o  (vid_out_o),
    .vid_addr_o (vid_addr_o),
    .vid_wr_o   (vid_wr_o),
    .regs       (regs_bus)
  );

endmodule

`default_nettype wire

/* test/tia_tb.sv */
`default_nettype none

module tia_tb;
  import tia_pkg::*;

  localparam int ROWS       = 8;
  localparam int FIXED_ROWS = 5;
  localparam int WATCHDOG   = ROWS * 3 * LINE_CLKS * FRAME_LINES * 8;

  typedef struct {
    logic [7:0] pf0, pf1, pf2, ctrlpf;
    logic [7:0] colup0, colupf, colubk;
    logic [7:0] grp0, grp_old;
    logic       refp0, vdelp0, enabl;
    int         p0_wait, bl_gap, line;    // Placement delays and line to sample
  } scene_t;

  logic               clk;
  logic               reset;
  logic               enable_i;
  logic               cpu_enable_i;
  logic               stb_i;
  logic               we_i;
  logic [ADDR_W-1:0]  adr_i;
  logic [DATA_W-1:0]  dat_i;
  logic               fire_i;
  logic [DATA_W-1:0]  dat_o;
  logic               stall_cpu_o;
  color_t             vid_out_o;
  logic               vid_vsync_o;
  logic               vid_vblank_o;
  logic [VADDR_W-1:0] vid_addr_o;
  logic               vid_wr_o;

  scene_t             rows[ROWS];
  color_t             line_pix[VISIBLE_W];
  int                 p0_x;
  int                 bl_x;
  int                 en_div;
  logic [31:0]        lfsr;
  logic               prev_wr;
  logic [VADDR_W-1:0] prev_addr;

  tia_top UUT (
    .clk (clk), .reset (reset), .enable_i (enable_i), .cpu_enable_i (cpu_enable_i),
    .stb_i (stb_i), .we_i (we_i), .adr_i (adr_i), .dat_i (dat_i), .fire_i (fire_i),
    .dat_o (dat_o), .stall_cpu_o (stall_cpu_o), .vid_out_o (vid_out_o),
    .vid_vsync_o (vid_vsync_o), .vid_vblank_o (vid_vblank_o),
    .vid_addr_o (vid_addr_o), .vid_wr_o (vid_wr_o)
  );

  always #4 clk = ~clk;

  // CPU bus runs at a third of the pixel clock
  always @(negedge clk) begin
    en_div       <= (en_div == 2) ? 0 : en_div + 1;
    cpu_enable_i <= (en_div == 2);
  end

  task automatic check_value(input logic [31:0] actual, input logic [31:0] expected,
                             input string what);
    if (actual !== expected) begin
      $display("mismatch at time %0t: %s, got %0h, expected %0h", $time, what, actual,
               expected);
      $display("Test failed");
      $fatal(1);
    end
  endtask

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("Test failed");
    $fatal(1);
  endtask

  // Frame buffer stream must be one unbroken run of 160 per line
  always @(negedge clk) begin
    if (!reset && vid_wr_o) begin
      if (prev_wr) begin
        check_value(32'(vid_addr_o), 32'(prev_addr + 16'd1), "address step");
        check_value(32'(int'(vid_addr_o) % VISIBLE_W == 0), 0, "write past line end");
      end else begin
        check_value(32'(int'(vid_addr_o) % VISIBLE_W), 0, "line start address");
      end
      if (int'(vid_addr_o) < (PICTURE_LINE - FIRST_LINE) * VISIBLE_W) begin
        check_value(32'(vid_out_o), 0, "pixel above picture");
      end
    end
    prev_wr   <= vid_wr_o;
    prev_addr <= vid_addr_o;
  end

  // Fibonacci LFSR, taps 32 22 2 1
  function automatic logic [7:0] rand_byte();
    logic [7:0] b;
    for (int i = 0; i < 8; i++) begin
      lfsr = {lfsr[30:0], lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0]};
      b = {b[6:0], lfsr[0]};
    end
    return b;
  endfunction

  task automatic bus_write(input logic [ADDR_W-1:0] a, input logic [DATA_W-1:0] d);
    @(negedge clk);
    stb_i = 1'b1;
    we_i  = 1'b1;
    adr_i = a;
    dat_i = d;
    @(negedge clk);
    while (!cpu_enable_i) @(negedge clk);   // Held until a CPU-enabled edge
    stb_i = 1'b0;
    we_i  = 1'b0;
  endtask

  task automatic bus_read(input logic [ADDR_W-1:0] a, output logic [DATA_W-1:0] d);
    @(negedge clk);
    stb_i = 1'b1;
    we_i  = 1'b0;
    adr_i = a;
    @(negedge clk);
    d     = dat_o;
    stb_i = 1'b0;
  endtask

  task automatic wait_pulses(input int n);
    int k;
    k = 0;
    while (k < n) begin
      @(negedge clk);
      if (vid_wr_o) k++;
    end
  endtask

  task automatic capture_line(input int line);
    int base;
    int n;
    int addr;
    base = (line - FIRST_LINE) * VISIBLE_W;
    n = 0;
    while (n < VISIBLE_W) begin
      @(negedge clk);
      addr = int'(vid_addr_o);
      if (vid_wr_o && addr >= base && addr < base + VISIBLE_W) begin
        line_pix[addr - base] = vid_out_o;
        n++;
      end
    end
  endtask

  task automatic set_row(input int r, input logic [7:0] pf0, pf1, pf2, ctrlpf, c0, cpf, cbk,
                         input logic [7:0] g0, gold, input logic refp, vdel, en,
                         input int p0w, blg, line);
    rows[r] = '{pf0, pf1, pf2, ctrlpf, c0, cpf, cbk, g0, gold, refp, vdel, en, p0w, blg, line};
  endtask

  task automatic apply_scene(input scene_t s);
    bus_write(A_COLUP0, s.colup0);
    bus_write(A_COLUPF, s.colupf);
    bus_write(A_COLUBK, s.colubk);
    bus_write(A_CTRLPF, s.ctrlpf);
    bus_write(A_PF0, s.pf0);
    bus_write(A_PF1, s.pf1);
    bus_write(A_PF2, s.pf2);
    bus_write(A_REFP0, {4'b0, s.refp0, 3'b0});
    bus_write(A_GRP0, s.grp_old);
    bus_write(A_GRP1, 8'h00);               // Moves grp_old into the delayed copy
    bus_write(A_GRP0, s.grp0);
    bus_write(A_ENABL, {6'b0, s.enabl, 1'b0});
    bus_write(A_VDELP0, {7'b0, s.vdelp0});
  endtask

  // PF0 bits 4..7, PF1 bits 7..0, PF2 bits 0..7 from left to right
  function automatic logic pf_model(input scene_t s, input int x);
    logic [19:0] pfw;
    int          col;
    for (int i = 0; i < 4; i++) pfw[i] = s.pf0[4 + i];
    for (int i = 0; i < 8; i++) pfw[4 + i] = s.pf1[7 - i];
    for (int i = 0; i < 8; i++) pfw[12 + i] = s.pf2[i];
    if (x < 80) begin
      col = x;
    end else if (s.ctrlpf[0]) begin
      col = 159 - x;
    end else begin
      col = x - 80;
    end
    return pfw[col / 4];
  endfunction

  task automatic check_scene(input scene_t s);
    logic       pf, bl, p0;
    logic [7:0] gfx;
    logic [2:0] cx;
    logic [7:0] d;
    color_t     pfc;
    color_t     exp_c;
    int         off;
    cx  = '0;
    gfx = s.vdelp0 ? s.grp_old : s.grp0;
    pfc = s.ctrlpf[1] ? s.colup0[7:1] : s.colupf[7:1];   // Score mode
    for (int x = 0; x < VISIBLE_W; x++) begin
      pf  = pf_model(s, x);
      bl  = s.enabl && x >= bl_x && x < bl_x + (1 << s.ctrlpf[5:4]);
      off = x - p0_x;
      p0  = off >= 0 && off < 8 && (s.refp0 ? gfx[off] : gfx[7 - off]);
      if (bl) exp_c = s.colupf[7:1];
      else if (s.ctrlpf[2] && pf) exp_c = pfc;
      else if (p0) exp_c = s.colup0[7:1];
      else if (pf) exp_c = pfc;
      else exp_c = s.colubk[7:1];
      check_value(32'(line_pix[x]), 32'(exp_c), $sformatf("pixel %0d line %0d", x, s.line));
      cx = cx | {bl && pf, p0 && bl, p0 && pf};
    end
    bus_read(6'h02, d);                     // Low nibble 2 selects CXP0FB
    check_value(32'(d), 32'({cx[0], cx[1], 6'b0}), "CXP0FB after scene");
    bus_read(6'h06, d);
    check_value(32'(d), 32'({cx[2], 7'b0}), "CXBLPF after scene");
  endtask

  task automatic place_objects(input scene_t s);
    int cnt;
    bus_write(A_WSYNC, 8'h00);
    check_value(32'(stall_cpu_o), 1, "stall after WSYNC");
    cnt = 0;
    while (stall_cpu_o) begin
      @(negedge clk);
      cnt++;
      if (cnt > LINE_CLKS) abort_run("CPU stall was not released within one line");
    end
    bus_write(A_GRP0, 8'hFF);               // Locator shapes
    bus_write(A_ENABL, 8'h02);
    bus_write(A_COLUP0, 8'h20);
    bus_write(A_COLUPF, 8'h40);
    wait_pulses(s.p0_wait);
    bus_write(A_RESP0, 8'h00);
    wait_pulses(s.bl_gap);
    bus_write(A_RESBL, 8'h00);
  endtask

  task automatic run_row(input int r);
    logic [7:0] d;
    fire_i = r[0];
    bus_write(A_VSYNC, 8'h02);
    check_value(32'(vid_vsync_o), 1, "VSYNC output");
    bus_write(A_VBLANK, 8'h02);
    check_value(32'(vid_vblank_o), 1, "VBLANK output high");
    bus_write(A_GRP0, 8'h00);
    bus_write(A_ENABL, 8'h00);
    bus_write(A_PF0, 8'h00);
    bus_write(A_PF1, 8'h00);
    bus_write(A_PF2, 8'h00);
    bus_write(A_CTRLPF, 8'h00);
    bus_write(A_REFP0, 8'h00);
    bus_write(A_VDELP0, 8'h00);
    bus_write(A_COLUBK, 8'h00);
    bus_write(A_VSYNC, 8'h00);
    check_value(32'(vid_vsync_o), 0, "VSYNC output low");
    bus_write(A_VBLANK, 8'h00);
    check_value(32'(vid_vblank_o), 0, "VBLANK output low");
    bus_write(A_CXCLR, 8'h00);
    wait_pulses(1);
    bus_read(6'h02, d);
    check_value(32'(d), 0, "CXP0FB after clear");
    bus_read(6'h06, d);
    check_value(32'(d), 0, "CXBLPF after clear");
    bus_read(6'h0C, d);
    check_value(32'(d), 32'({fire_i, 7'b0}), "INPT4");
    place_objects(rows[r]);
    capture_line(PICTURE_LINE);
    p0_x = -1;
    bl_x = -1;
    for (int x = VISIBLE_W - 1; x >= 0; x--) begin
      if (line_pix[x] == 7'h10) p0_x = x;
      if (line_pix[x] == 7'h20) bl_x = x;
    end
    if (p0_x < 0 || bl_x < 0) abort_run("Player or ball was not found on the locator line");
    apply_scene(rows[r]);
    bus_write(A_CXCLR, 8'h00);
    capture_line(rows[r].line);
    check_scene(rows[r]);
  endtask

  initial begin
    #WATCHDOG;
    abort_run("Simulation timed out before all rows finished");
  end

  initial begin
    logic [7:0] b;
    clk = 1'b0;
    reset = 1'b1;
    enable_i = 1'b1;
    cpu_enable_i = 1'b0;
    en_div = 0;
    stb_i = 1'b0;
    we_i = 1'b0;
    adr_i = '0;
    dat_i = '0;
    fire_i = 1'b0;
    prev_wr = 1'b0;
    prev_addr = '0;
    lfsr = 32'h0455_24f1;
    set_row(0, 8'h00, 8'h00, 8'h00, 8'h00, 8'h1E, 8'h3C, 8'h84, 8'h00, 8'h00, 0, 0, 0, 10, 20, 40);
    set_row(1, 8'hA0, 8'h5A, 8'hC3, 8'h00, 8'h1E, 8'h3C, 8'h84, 8'h00, 8'h00, 0, 0, 0, 30, 30, 42);
    set_row(2, 8'h50, 8'h93, 8'h0F, 8'h03, 8'h1E, 8'h3C, 8'h84, 8'h3C, 8'h00, 0, 0, 0, 20, 10, 44);
    set_row(3, 8'hF0, 8'hFF, 8'h81, 8'h30, 8'h2A, 8'h5C, 8'h92, 8'hB1, 8'h00, 0, 0, 1, 40, 0, 46);
    set_row(4, 8'h70, 8'hC5, 8'h3A, 8'h25, 8'h66, 8'hD8, 8'h0E, 8'h0F, 8'hE4, 1, 1, 1, 25, 2, 48);
    for (int r = FIXED_ROWS; r < ROWS; r++) begin
      b = rand_byte();
      set_row(r, rand_byte(), rand_byte(), rand_byte(), rand_byte() & 8'h37, rand_byte(),
              rand_byte(), rand_byte(), rand_byte(), rand_byte(), b[0], b[1], 1'b1,
              15 + int'(rand_byte()) % 40, int'(b[7:5]), 50 + r);
    end
    repeat (2) @(posedge clk);
    @(negedge clk);
    reset = 1'b0;
    check_value(32'({stall_cpu_o, vid_wr_o, vid_vsync_o, vid_vblank_o}), 0,
                "outputs after reset");
    for (int r = 0; r < ROWS; r++) begin
      run_row(r);
    end
    $display("Test completed successfully");
    $finish;
  end

endmodule

`default_nettype wire

/* compile.f */
source/tia_pkg.sv
source/tia_regs_if.sv
source/tia_regs.sv
source/beam_counter.sv
source/object_render.sv
source/pixel_out.sv
source/tia_top.sv
test/tia_tb.sv

/* Makefile */
SIM      = verilator
FLAGS    = --binary --timing -j 0
TOP      = tia_tb
FILELIST = compile.f

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list the targets"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory"

test:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST)
	@out=$$(./obj_dir/V$(TOP)); echo "$$out"; \
	echo "$$out" | grep -q "Test completed successfully"

clean:
	rm -rf obj_dir
